// ==== Bender.yml ====
package:
  name: piano_synth

sources:
  # Package first, then the blocks, then the top level
  - verilog/pianoPkg.sv
  - verilog/ps2Receiver.sv
  - verilog/keyDecoder.sv
  - verilog/toneBank.sv
  - verilog/dacSerializer.sv
  - verilog/pianoTop.sv

  - target: test
    files:
      - verif/tbClock.sv
      - verif/pianoTb.sv

// ==== src.f ====
verilog/pianoPkg.sv
verilog/ps2Receiver.sv
verilog/keyDecoder.sv
verilog/toneBank.sv
verilog/dacSerializer.sv
verilog/pianoTop.sv
verif/tbClock.sv
verif/pianoTb.sv

// ==== verif/pianoTb.sv ====
// Keyboard synthesizer testbench
`timescale 1ns/1ns

module pianoTb import pianoPkg::*; ();

	localparam int PS2_HALF = 600; // System clocks per PS/2 half period
	localparam int FRAME_CYCLES = 2 * DAC_FRAME_W + 2;
	localparam int CS_LIMIT = 4 * FRAME_CYCLES;
	localparam int SCK_LIMIT = 8;
	localparam logic [31:0] SEED = 32'hc0b4_db1a;

	logic CLK;
	logic rst;
	logic ps2Clk;
	logic ps2Data;
	logic spiMosi;
	logic spiSck;
	logic dacCsN;

	longint cycle; // Clocks since reset release
	heldNotes_t heldModel;
	logic breakModel;
	logic [31:0] lfsrState;
	logic [31:0] rnd;
	logic [7:0] oddCode;
	int keys [3];
	int nKeys;

	tbClock u_clock (.CLK(CLK), .rst(rst));

	pianoTop u_dut (
		.CLK     (CLK),
		.rst     (rst),
		.ps2Clk  (ps2Clk),
		.ps2Data (ps2Data),
		.spiMosi (spiMosi),
		.spiSck  (spiSck),
		.dacCsN  (dacCsN)
	);

	always @(posedge CLK) begin
		if (rst)
			cycle <= 0;
		else
			cycle <= cycle + 1;
	end

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stopRun($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
	endtask

	task automatic checkFrame(input string name, input dacFrame_t got, input dacFrame_t exp);
		if (got !== exp)
			stopRun($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
	endtask

	task automatic checkCycles(input string name, input longint got, input longint exp);
		if (got != exp)
			stopRun($sformatf("ERR %s got 0x%h exp 0x%h", name, got, exp));
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawBits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			val = {val[30:0], lfsrState[0]};
		end
	endtask

	function automatic logic isMapped(input logic [7:0] code);
		for (int i = 0; i < NOTE_COUNT; i++) begin
			if (KEY_CODE[i] == code)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// Divider value is the cycle count folded by each note's period
	function automatic logic modelMix(input longint m);
		logic acc;
		longint cnt;
		acc = 1'b0;
		for (int i = 0; i < NOTE_COUNT; i++) begin
			cnt = (m < 0) ? 0 : m % (longint'(TONE_LAST[i]) + 1);
			acc |= heldModel[i] & cnt[TONE_TAP];
		end
		return acc;
	endfunction

	task automatic modelByte(input logic [7:0] b);
		if (b == PS2_BREAK_CODE) begin
			breakModel = 1'b1;
		end else begin
			for (int i = 0; i < NOTE_COUNT; i++) begin
				if (KEY_CODE[i] == b)
					heldModel[i] = ~breakModel;
			end
			breakModel = 1'b0;
		end
	endtask

	// Start, 8 data bits LSB first, parity, stop
	task automatic sendFrame(input logic [7:0] data, input logic badParity, input int nBits);
		logic [10:0] bits;
		bits = {1'b1, (~^data) ^ badParity, data, 1'b0};
		for (int i = 0; i < nBits; i++) begin
			ps2Data = bits[i];
			repeat (PS2_HALF) @(negedge CLK);
			ps2Clk = 1'b0; // Keyboard clock low, bit valid
			repeat (PS2_HALF) @(negedge CLK);
			ps2Clk = 1'b1;
		end
		ps2Data = 1'b1;
		repeat (PS2_HALF) @(negedge CLK);
	endtask

	task automatic sendByte(input logic [7:0] b);
		sendFrame(b, 1'b0, 11);
		modelByte(b);
	endtask

	task automatic pressKey(input int idx);
		sendByte(KEY_CODE[idx]);
	endtask

	task automatic releaseKey(input int idx);
		sendByte(PS2_BREAK_CODE);
		sendByte(KEY_CODE[idx]);
	endtask

	task automatic pickFreeKey(output int idx);
		logic [31:0] r;
		drawBits(5, r);
		idx = r % NOTE_COUNT;
		while (heldModel[idx])
			idx = (idx + 1) % NOTE_COUNT;
	endtask

	task automatic pickUnmapped(output logic [7:0] code);
		logic [31:0] r;
		drawBits(8, r);
		code = r[7:0];
		while (isMapped(code) || code == PS2_BREAK_CODE)
			code = code + 1'b1;
	endtask

	task automatic waitReset();
		int n;
		n = 0;
		while (rst !== 1'b0) begin
			@(posedge CLK);
			n++;
			if (n > 16)
				stopRun("Reset was not released in time");
		end
		@(negedge CLK);
	endtask

	task automatic waitCs(input logic level);
		int n;
		n = 0;
		while (dacCsN !== level) begin
			@(negedge CLK);
			n++;
			if (n > CS_LIMIT)
				stopRun($sformatf("dacCsN did not go to %0d in time", level));
		end
	endtask

	task automatic waitSck(input logic level);
		int n;
		n = 0;
		while (spiSck !== level) begin
			@(negedge CLK);
			n++;
			if (n > SCK_LIMIT)
				stopRun($sformatf("spiSck did not go to %0d in time", level));
		end
	endtask

	// SPI monitor, one bit per SCK rise while selected
	task automatic captureFrame(output dacFrame_t got, output longint csCycle);
		logic [DAC_FRAME_W-1:0] bits;
		waitCs(1'b1);
		waitCs(1'b0);
		csCycle = cycle;
		for (int i = DAC_FRAME_W - 1; i >= 0; i--) begin
			waitSck(1'b1);
			if (dacCsN !== 1'b0)
				stopRun("dacCsN went high in the middle of a frame");
			bits[i] = spiMosi;
			waitSck(1'b0);
		end
		got = dacFrame_t'(bits);
	endtask

	task automatic checkFrames(input int n);
		dacFrame_t got;
		dacFrame_t masked;
		dacFrame_t exp;
		longint csCycle;
		longint lastCs;
		logic audio;
		logic stable;
		lastCs = 0;
		for (int i = 0; i < n; i++) begin
			captureFrame(got, csCycle);
			if (i > 0)
				checkCycles("framePeriod", csCycle - lastCs, FRAME_CYCLES);
			lastCs = csCycle;
			audio = modelMix(csCycle - 2); // Mix register, then frame load
			stable = 1'b1;
			for (longint m = csCycle - 4; m <= csCycle; m++) begin
				if (modelMix(m) != audio)
					stable = 1'b0;
			end
			exp.lead = '0;
			exp.cmd = DAC_WRITE_UPDATE;
			exp.addr = 4'h0;
			exp.sample = '0;
			exp.tail = '0;
			masked = got;
			masked.sample[SAMPLE_W-1] = 1'b0;
			checkFrame("dacFrame", masked, exp);
			if (stable)
				checkBit("sampleMsb", got.sample[SAMPLE_W-1], audio);
		end
	endtask

	// Random gaps move the checks across the slow tone periods
	task automatic spacedChecks(input int n);
		logic [31:0] gap;
		for (int i = 0; i < n; i++) begin
			checkFrames(2);
			drawBits(16, gap);
			repeat (gap) @(negedge CLK);
		end
	endtask

	initial begin
		ps2Clk = 1'b1;
		ps2Data = 1'b1;
		heldModel = '0;
		breakModel = 1'b0;
		lfsrState = SEED;
		@(negedge CLK);
		checkBit("dacCsN", dacCsN, 1'b1);
		checkBit("spiSck", spiSck, 1'b0);
		waitReset();
		checkBit("dacCsN", dacCsN, 1'b0); // First frame already started
		checkCycles("firstCsCycle", cycle, 1);
		checkFrames(4);
		spacedChecks(2);

		// Single note, then its release
		pickFreeKey(keys[0]);
		pressKey(keys[0]);
		spacedChecks(6);
		releaseKey(keys[0]);
		spacedChecks(4);

		// Chord of two or three notes, then one of them let go
		drawBits(1, rnd);
		nKeys = 2 + rnd[0];
		for (int i = 0; i < nKeys; i++) begin
			pickFreeKey(keys[i]);
			pressKey(keys[i]);
		end
		spacedChecks(6);
		drawBits(2, rnd);
		releaseKey(keys[rnd % nKeys]);
		spacedChecks(6);
		for (int i = 0; i < nKeys; i++) begin
			releaseKey(keys[i]);
		end

		// Bad parity and unmapped codes
		pickFreeKey(keys[0]);
		pressKey(keys[0]);
		pickFreeKey(keys[1]);
		sendFrame(KEY_CODE[keys[1]], 1'b1, 11);
		spacedChecks(4);
		pickUnmapped(oddCode);
		sendByte(oddCode);
		spacedChecks(4);
		releaseKey(keys[0]);

		// Truncated frame must time out before the next make code
		pickFreeKey(keys[0]);
		sendFrame(KEY_CODE[keys[0]], 1'b0, 5);
		repeat ((PS2_TIMEOUT_TICKS + 8) * PS2_TICK_DIV) @(negedge CLK);
		pressKey(keys[0]);
		spacedChecks(4);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== verif/tbClock.sv ====
// Testbench clock and reset
`timescale 1ns/1ns

module tbClock (
	output logic CLK,
	output logic rst
);

	localparam int HALF_PERIOD = 2; // 4 ns clock
	localparam int RESET_CYCLES = 3;

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	// Release on a falling edge, away from the DUT's sampling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge CLK);
		rst = 1'b0;
	end

endmodule

// ==== verilog/dacSerializer.sv ====
// SPI DAC frame serializer
`timescale 1ns/1ns

module dacSerializer import pianoPkg::*; (
	input  logic CLK,
	input  logic rst,
	input  logic mix,
	output logic spiMosi,
	output logic spiSck,
	output logic dacCsN
);

	// Each state names the action taken at the next clock edge
	typedef enum logic [2:0] {
		CAPTURE,  // Select DAC, load word, present MSB
		HIGH,     // Raise SCK, DAC samples here
		LOW,      // Drop SCK and present the next bit
		TAIL,     // Final SCK low
		DESELECT  // Release CS
	} dacState_e;

	dacState_e state;
	dacFrame_t newFrame;
	dacFrame_t shiftReg;
	logic [DAC_BIT_W-1:0] bitIdx; // Index of the bit on MOSI

	always_comb begin
		newFrame.lead = '0;
		newFrame.cmd = DAC_WRITE_UPDATE;
		newFrame.addr = DAC_CHANNEL;
		newFrame.sample = {mix, {(SAMPLE_W - 1){1'b0}}}; // Audio in the MSB only
		newFrame.tail = '0;
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= CAPTURE;
			bitIdx <= '0;
			dacCsN <= 1'b1;
			spiSck <= 1'b0;
			spiMosi <= 1'b0;
		end else begin
			case (state)
				CAPTURE: begin
					dacCsN <= 1'b0;
					spiSck <= 1'b0;
					spiMosi <= newFrame[DAC_FRAME_W-1];
					bitIdx <= DAC_BIT_W'(DAC_FRAME_W - 1);
					state <= HIGH;
				end
				HIGH: begin
					spiSck <= 1'b1;
					state <= (bitIdx == '0) ? TAIL : LOW;
				end
				LOW: begin
					spiSck <= 1'b0;
					spiMosi <= shiftReg[DAC_FRAME_W-2];
					bitIdx <= bitIdx - 1'b1;
					state <= HIGH;
				end
				TAIL: begin
					spiSck <= 1'b0;
					state <= DESELECT;
				end
				DESELECT: begin
					dacCsN <= 1'b1;
					spiMosi <= 1'b0;
					state <= CAPTURE; // Next frame follows at once
				end
				default: state <= CAPTURE;
			endcase
		end
	end

	// Word register, MSB always aligned with MOSI
	always_ff @(posedge CLK) begin
		if (state == CAPTURE)
			shiftReg <= newFrame;
		else if (state == LOW)
			shiftReg <= dacFrame_t'({shiftReg[DAC_FRAME_W-2:0], 1'b0});
	end

endmodule

// ==== verilog/keyDecoder.sv ====
// Scan code to held notes
`timescale 1ns/1ns

module keyDecoder import pianoPkg::*; (
	input  logic       CLK,
	input  logic       rst,
	input  logic       byteStrobe,
	input  logic [7:0] byteData,
	output heldNotes_t held
);

	logic breakPending; // Last byte was the release prefix
	logic isBreak;
	heldNotes_t keyHit;

	// At most one note matches a given code
	always_comb begin
		for (int i = 0; i < NOTE_COUNT; i++) begin
			keyHit[i] = byteData == KEY_CODE[i];
		end
	end

	assign isBreak = byteData == PS2_BREAK_CODE;

	always_ff @(posedge CLK) begin
		if (rst) begin
			held <= '0;
			breakPending <= 1'b0;
		end else if (byteStrobe) begin
			breakPending <= isBreak;
			if (!isBreak) begin
				if (breakPending)
					held <= held & ~keyHit; // Release
				else
					held <= held | keyHit; // Press, repeats are harmless
			end
		end
	end

endmodule

// ==== verilog/pianoPkg.sv ====
// Keyboard synthesizer definitions
package pianoPkg;

	localparam int NOTE_COUNT = 19;

	// Playable notes in rising pitch order
	typedef enum logic [4:0] {
		NOTE_LA2, NOTE_SI2, NOTE_DO3, NOTE_RE3, NOTE_MI3, NOTE_FA3, NOTE_SOL3,
		NOTE_LA3, NOTE_SI3, NOTE_DO4, NOTE_RE4, NOTE_MI4, NOTE_FA4, NOTE_SOL4,
		NOTE_LA4, NOTE_SI4, NOTE_DO5, NOTE_RE5, NOTE_MI5
	} note_e;

	typedef logic [NOTE_COUNT-1:0] heldNotes_t; // One bit per note, set while held

	// Make codes, lower row then upper row of the keyboard
	localparam logic [7:0] KEY_CODE [NOTE_COUNT] = '{
		8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h34, 8'h33, 8'h3B, 8'h42, 8'h4B, // A to L
		8'h15, 8'h1D, 8'h24, 8'h2D, 8'h2C, 8'h35, 8'h3C, 8'h43, 8'h44, // Q to O
		8'h4D                                                          // P
	};

	localparam logic [7:0] PS2_BREAK_CODE = 8'hF0;

	localparam int PS2_TICK_DIV = 250;
	localparam int PS2_TICK_W = $clog2(PS2_TICK_DIV);
	localparam int PS2_TIMEOUT_TICKS = 4000;
	localparam int PS2_IDLE_W = $clog2(PS2_TIMEOUT_TICKS + 1);
	localparam int PS2_FRAME_BITS = 11; // Start, 8 data, parity, stop
	localparam int PS2_BITCNT_W = $clog2(PS2_FRAME_BITS + 1);

	localparam int TONE_CNT_W = 21;
	localparam int TONE_TAP = 16;

	// Divider terminal counts, A2 first
	localparam logic [TONE_CNT_W-1:0] TONE_LAST [NOTE_COUNT] = '{
		21'd454545, 21'd404957, 21'd382234, 21'd340530, 21'd303380,
		21'd286352, 21'd255102, 21'd227272, 21'd202478, 21'd191109,
		21'd170648, 21'd151976, 21'd143266, 21'd127877, 21'd113636,
		21'd101420, 21'd95602,  21'd85131,  21'd75843
	};

	localparam int SAMPLE_W = 12;

	typedef enum logic [3:0] {
		DAC_WRITE_UPDATE = 4'b0011 // Write input register and update output
	} dacCmd_e;

	localparam logic [3:0] DAC_CHANNEL = 4'd0;

	// DAC word, shifted out MSB first
	typedef struct packed {
		logic [7:0]          lead;
		dacCmd_e             cmd;
		logic [3:0]          addr;
		logic [SAMPLE_W-1:0] sample;
		logic [3:0]          tail;
	} dacFrame_t;

	localparam int DAC_FRAME_W = $bits(dacFrame_t);
	localparam int DAC_BIT_W = $clog2(DAC_FRAME_W);

endpackage

// ==== verilog/pianoTop.sv ====
// Keyboard synthesizer top
`timescale 1ns/1ns

module pianoTop import pianoPkg::*; (
	input  logic CLK,
	input  logic rst,
	input  logic ps2Clk,
	input  logic ps2Data,
	output logic spiMosi,
	output logic spiSck,
	output logic dacCsN
);

	logic byteStrobe;
	logic [7:0] byteData;
	heldNotes_t held;
	logic mix; // One-bit audio

	ps2Receiver u_receiver (
		.CLK        (CLK),
		.rst        (rst),
		.ps2Clk     (ps2Clk),
		.ps2Data    (ps2Data),
		.byteStrobe (byteStrobe),
		.byteData   (byteData)
	);

	keyDecoder u_decoder (
		.CLK        (CLK),
		.rst        (rst),
		.byteStrobe (byteStrobe),
		.byteData   (byteData),
		.held       (held)
	);

	toneBank u_toneBank (
		.CLK  (CLK),
		.rst  (rst),
		.held (held),
		.mix  (mix)
	);

	dacSerializer u_dac (
		.CLK     (CLK),
		.rst     (rst),
		.mix     (mix),
		.spiMosi (spiMosi),
		.spiSck  (spiSck),
		.dacCsN  (dacCsN)
	);

endmodule

// ==== verilog/ps2Receiver.sv ====
// PS/2 keyboard receiver
`timescale 1ns/1ns

module ps2Receiver import pianoPkg::*; (
	input  logic       CLK,
	input  logic       rst,
	input  logic       ps2Clk,
	input  logic       ps2Data,
	output logic       byteStrobe,
	output logic [7:0] byteData
);

	logic [PS2_TICK_W-1:0] tickCnt;
	logic tick;
	logic [1:0] clkSync;
	logic [1:0] dataSync;
	logic prevClk;
	logic fallEdge;
	logic frameFull;
	logic frameOk;
	logic [PS2_FRAME_BITS-1:0] frame;
	logic [PS2_BITCNT_W-1:0] bitCnt;
	logic [PS2_IDLE_W-1:0] idleCnt;

	// Slow sample tick
	always_ff @(posedge CLK) begin
		if (rst) begin
			tickCnt <= '0;
			tick <= 1'b0;
		end else if (tickCnt == PS2_TICK_W'(PS2_TICK_DIV - 1)) begin
			tickCnt <= '0;
			tick <= 1'b1;
		end else begin
			tickCnt <= tickCnt + 1'b1;
			tick <= 1'b0;
		end
	end

	// Keyboard lines are asynchronous, both idle high
	always_ff @(posedge CLK) begin
		if (rst) begin
			clkSync <= 2'b11;
			dataSync <= 2'b11;
		end else begin
			clkSync <= {clkSync[0], ps2Clk};
			dataSync <= {dataSync[0], ps2Data};
		end
	end

	assign fallEdge = prevClk & ~clkSync[1];
	assign frameFull = bitCnt == PS2_BITCNT_W'(PS2_FRAME_BITS);
	// Start low, stop high, odd parity over data and parity bit
	assign frameOk = ~frame[0] & frame[PS2_FRAME_BITS-1] & (^frame[PS2_FRAME_BITS-2:1]);

	always_ff @(posedge CLK) begin
		if (rst) begin
			prevClk <= 1'b1;
			bitCnt <= '0;
			idleCnt <= '0;
			byteStrobe <= 1'b0;
		end else begin
			byteStrobe <= 1'b0;
			if (tick) begin
				prevClk <= clkSync[1];
				if (frameFull) begin
					bitCnt <= '0;
					idleCnt <= '0;
					byteStrobe <= frameOk; // Bad frames vanish here
				end else if (fallEdge) begin
					bitCnt <= bitCnt + 1'b1;
					idleCnt <= '0;
				end else if (bitCnt != '0) begin
					if (idleCnt == PS2_IDLE_W'(PS2_TIMEOUT_TICKS)) begin
						bitCnt <= '0; // Partial frame timed out
						idleCnt <= '0;
					end else begin
						idleCnt <= idleCnt + 1'b1;
					end
				end
			end
		end
	end

	// Bits arrive LSB first and shift in from the top
	always_ff @(posedge CLK) begin
		if (tick && fallEdge && !frameFull)
			frame <= {dataSync[1], frame[PS2_FRAME_BITS-1:1]};
		if (tick && frameFull)
			byteData <= frame[8:1];
	end

endmodule

// ==== verilog/toneBank.sv ====
// Note dividers and mixer
`timescale 1ns/1ns

module toneBank import pianoPkg::*; (
	input  logic       CLK,
	input  logic       rst,
	input  heldNotes_t held,
	output logic       mix
);

	logic [TONE_CNT_W-1:0] toneCnt [NOTE_COUNT];
	heldNotes_t toneBits;

	// Square wave of each note, free running
	always_comb begin
		for (int i = 0; i < NOTE_COUNT; i++) begin
			toneBits[i] = toneCnt[i][TONE_TAP];
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < NOTE_COUNT; i++) begin
				toneCnt[i] <= '0;
			end
			mix <= 1'b0;
		end else begin
			for (int i = 0; i < NOTE_COUNT; i++) begin
				if (toneCnt[i] == TONE_LAST[i])
					toneCnt[i] <= '0;
				else
					toneCnt[i] <= toneCnt[i] + 1'b1;
			end
			mix <= |(held & toneBits); // Chords simply OR together
		end
	end

endmodule
